// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// Processor and system buses share one address and word format
	localparam int addr_w = 16;
	localparam int data_w = 16;
	localparam int wait_w = 4;

	// Word address, no byte lanes
	typedef logic [addr_w-1:0] addr_t;

	typedef logic [data_w-1:0] data_t;

	typedef logic [wait_w-1:0] wait_t; // Wait-state count

	// Bus direction, same encoding on both buses
	typedef enum logic {
		rw_read  = 1'b0,
		rw_write = 1'b1
	} rw_e;

endpackage

`default_nettype wire

// File: source/proc_port.sv
`timescale 1ns/100ps
`default_nettype none

module proc_port (
	input  wire logic              clock,
	input  wire logic              rst_n,
	input  wire logic              accept,
	input  wire cache_pkg::rw_e    proc_rw,
	input  wire cache_pkg::addr_t  proc_addr,
	input  wire cache_pkg::data_t  proc_wdata,
	input  wire logic              rdata_from_sys,
	input  wire cache_pkg::data_t  line_data,
	input  wire cache_pkg::data_t  fetched,
	output cache_pkg::rw_e         req_rw,
	output cache_pkg::addr_t       req_addr,
	output cache_pkg::data_t       req_wdata,
	output cache_pkg::data_t       proc_rdata
);

	cache_pkg::rw_e rw_q;

	// Direction of the accepted request
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rw_q <= cache_pkg::rw_read;
		end else if (accept) begin
			rw_q <= proc_rw;
		end
	end

	// Address and write data held for the whole transaction
	always_ff @(posedge clock) begin
		if (accept) begin
			req_addr  <= proc_addr;
			req_wdata <= proc_wdata;
		end
	end

	// Live direction in the accept cycle, so the FSM can branch from idle
	assign req_rw = accept ? proc_rw : rw_q;

	// Hit data from the line, miss data straight from the system word
	assign proc_rdata = rdata_from_sys ? fetched : line_data;

endmodule

`default_nettype wire

// File: source/cache_store.sv
`timescale 1ns/100ps
`default_nettype none

module cache_store #(
	parameter int index_bits = 4
) (
	input  wire logic              clock,
	input  wire logic              rst_n,
	input  wire cache_pkg::addr_t  req_addr,
	input  wire logic              fill,
	input  wire logic              fill_from_sys,
	input  wire cache_pkg::data_t  req_wdata,
	input  wire cache_pkg::data_t  fetched,
	output logic                   hit,
	output cache_pkg::data_t       line_data
);

	localparam int lines = 1 << index_bits;
	localparam int tag_w = cache_pkg::addr_w - index_bits;

	typedef logic [index_bits-1:0] index_t;
	typedef logic [tag_w-1:0]      tag_t;

	index_t           index;
	tag_t             tag;
	tag_t             tag_mem  [lines];
	cache_pkg::data_t data_mem [lines];
	logic [lines-1:0] valid;

	// Low bits pick the line, the rest is the tag
	assign index = req_addr[index_bits-1:0];
	assign tag   = req_addr[cache_pkg::addr_w-1:index_bits];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid <= '0; // Whole cache invalid
		end else if (fill) begin
			valid[index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill) begin
			tag_mem[index]  <= tag;
			data_mem[index] <= fill_from_sys ? fetched : req_wdata; // Refill or write
		end
	end

	assign hit       = valid[index] && (tag_mem[index] == tag);
	assign line_data = data_mem[index];

endmodule

`default_nettype wire

// File: source/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
	input  wire logic            clock,
	input  wire logic            rst_n,
	input  wire logic            proc_strobe,
	input  wire cache_pkg::rw_e  req_rw,
	input  wire logic            hit,
	input  wire logic            sys_done,
	output logic                 accept,
	output logic                 proc_ready,
	output logic                 fill,
	output logic                 fill_from_sys,
	output logic                 rdata_from_sys,
	output logic                 sys_start
);

	typedef enum logic [3:0] {
		idle,
		read,
		read_miss,
		read_sys,
		read_data,
		write,
		write_start,
		write_sys,
		write_data
	} state_e;

	state_e state;
	state_e next_state;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		unique case (state)
			idle: begin
				if (accept) begin
					if (req_rw == cache_pkg::rw_write) begin
						next_state = write;
					end else begin
						next_state = read;
					end
				end
			end
			read: begin
				if (hit) begin
					next_state = idle; // Answered from the cache
				end else begin
					next_state = read_miss;
				end
			end
			read_miss: begin
				next_state = read_sys;
			end
			read_sys: begin
				if (sys_done) begin
					next_state = read_data;
				end
			end
			read_data: begin
				next_state = idle;
			end
			// Write hit and miss take the same path, the line is always written
			write: begin
				next_state = write_start;
			end
			write_start: begin
				next_state = write_sys;
			end
			write_sys: begin
				if (sys_done) begin
					next_state = write_data;
				end
			end
			write_data: begin
				next_state = idle;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	// Moore outputs, except accept and the hit ready
	always_comb begin
		accept         = 1'b0;
		proc_ready     = 1'b0;
		fill           = 1'b0;
		fill_from_sys  = 1'b0;
		rdata_from_sys = 1'b0;
		sys_start      = 1'b0;
		unique case (state)
			idle: begin
				accept = proc_strobe;
			end
			read: begin
				proc_ready = hit;
			end
			read_miss: begin
				sys_start = 1'b1;
			end
			read_data: begin
				fill           = 1'b1;
				fill_from_sys  = 1'b1; // Line takes the fetched word
				rdata_from_sys = 1'b1;
				proc_ready     = 1'b1;
			end
			write_start: begin
				fill      = 1'b1;
				sys_start = 1'b1;
			end
			write_data: begin
				proc_ready = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/sys_port.sv
`timescale 1ns/100ps
`default_nettype none

module sys_port #(
	parameter int wait_states = 3
) (
	input  wire logic              clock,
	input  wire logic              rst_n,
	input  wire logic              sys_start,
	input  wire cache_pkg::rw_e    req_rw,
	input  wire cache_pkg::addr_t  req_addr,
	input  wire cache_pkg::data_t  req_wdata,
	input  wire cache_pkg::data_t  sys_rdata,
	output logic                   sys_strobe,
	output cache_pkg::rw_e         sys_rw,
	output cache_pkg::addr_t       sys_addr,
	output cache_pkg::data_t       sys_wdata,
	output logic                   sys_done,
	output cache_pkg::data_t       fetched
);

	cache_pkg::wait_t count;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			sys_strobe <= 1'b0;
			count      <= '0;
		end else begin
			sys_strobe <= sys_start; // One-cycle pulse
			if (sys_start) begin
				count <= cache_pkg::wait_t'(wait_states);
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
		end
	end

	// Request held on the bus until the next start
	always_ff @(posedge clock) begin
		if (sys_start) begin
			sys_rw    <= req_rw;
			sys_addr  <= req_addr;
			sys_wdata <= req_wdata;
		end
	end

	// Last wait cycle, count hits zero on this edge
	assign sys_done = (count == cache_pkg::wait_t'(1));

	always_ff @(posedge clock) begin
		if (sys_done) begin
			fetched <= sys_rdata;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
	parameter int index_bits  = 4,
	parameter int wait_states = 3
) (
	input  wire logic              clock,
	input  wire logic              rst_n,
	input  wire logic              proc_strobe,
	input  wire cache_pkg::rw_e    proc_rw,
	input  wire cache_pkg::addr_t  proc_addr,
	input  wire cache_pkg::data_t  proc_wdata,
	output logic                   proc_ready,
	output cache_pkg::data_t       proc_rdata,
	output logic                   sys_strobe,
	output cache_pkg::rw_e         sys_rw,
	output cache_pkg::addr_t       sys_addr,
	output cache_pkg::data_t       sys_wdata,
	input  wire cache_pkg::data_t  sys_rdata
);

	logic             accept;
	logic             hit;
	logic             fill;
	logic             fill_from_sys;
	logic             rdata_from_sys;
	logic             sys_start;
	logic             sys_done;
	cache_pkg::rw_e   req_rw;
	cache_pkg::addr_t req_addr;
	cache_pkg::data_t req_wdata;
	cache_pkg::data_t line_data;
	cache_pkg::data_t fetched;

	// Processor side
	proc_port u_proc_port (
		.clock          (clock),
		.rst_n          (rst_n),
		.accept         (accept),
		.proc_rw        (proc_rw),
		.proc_addr      (proc_addr),
		.proc_wdata     (proc_wdata),
		.rdata_from_sys (rdata_from_sys),
		.line_data      (line_data),
		.fetched        (fetched),
		.req_rw         (req_rw),
		.req_addr       (req_addr),
		.req_wdata      (req_wdata),
		.proc_rdata     (proc_rdata)
	);

	cache_store #(
		.index_bits (index_bits)
	) u_cache_store (
		.clock         (clock),
		.rst_n         (rst_n),
		.req_addr      (req_addr),
		.fill          (fill),
		.fill_from_sys (fill_from_sys),
		.req_wdata     (req_wdata),
		.fetched       (fetched),
		.hit           (hit),
		.line_data     (line_data)
	);

	cache_ctrl u_cache_ctrl (
		.clock          (clock),
		.rst_n          (rst_n),
		.proc_strobe    (proc_strobe),
		.req_rw         (req_rw),
		.hit            (hit),
		.sys_done       (sys_done),
		.accept         (accept),
		.proc_ready     (proc_ready),
		.fill           (fill),
		.fill_from_sys  (fill_from_sys),
		.rdata_from_sys (rdata_from_sys),
		.sys_start      (sys_start)
	);

	// System memory side
	sys_port #(
		.wait_states (wait_states)
	) u_sys_port (
		.clock      (clock),
		.rst_n      (rst_n),
		.sys_start  (sys_start),
		.req_rw     (req_rw),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.sys_rdata  (sys_rdata),
		.sys_strobe (sys_strobe),
		.sys_rw     (sys_rw),
		.sys_addr   (sys_addr),
		.sys_wdata  (sys_wdata),
		.sys_done   (sys_done),
		.fetched    (fetched)
	);

endmodule

`default_nettype wire

// File: sim/cache_chk.sv
`timescale 1ns/100ps
`default_nettype none

module cache_chk (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic accept,
	input wire logic proc_ready,
	input wire logic sys_start
);

	logic open_req;
	int   fail_count = 0;

	// Request open from accept until ready
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			open_req <= 1'b0;
		end else if (accept) begin
			open_req <= 1'b1;
		end else if (proc_ready) begin
			open_req <= 1'b0;
		end
	end

	start_pulse: assert property (@(posedge clock) disable iff (!rst_n) sys_start |=> !sys_start)
		else begin
			$error("sys_start held for two cycles");
			fail_count++;
		end

	ready_not_start: assert property (@(posedge clock) disable iff (!rst_n)
		!(proc_ready && sys_start))
		else begin
			$error("proc_ready and sys_start in the same cycle");
			fail_count++;
		end

	accept_idle: assert property (@(posedge clock) disable iff (!rst_n) accept |-> !open_req)
		else begin
			$error("accept while a request is still open");
			fail_count++;
		end

endmodule

bind cache_ctrl cache_chk u_chk (
	.clock      (clock),
	.rst_n      (rst_n),
	.accept     (accept),
	.proc_ready (proc_ready),
	.sys_start  (sys_start)
);

`default_nettype wire

// File: sim/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache;

	localparam int index_bits     = 4;
	localparam int wait_states    = 3;
	localparam int tag_w          = cache_pkg::addr_w - index_bits;
	localparam int lines          = 1 << index_bits;
	localparam int mem_lat        = wait_states - 2; // Word valid in the last wait cycle
	localparam int timeout_cycles = 60 * (wait_states + 4) + 100;

	logic             clock = 1'b0;
	logic             rst_n;
	logic             proc_strobe;
	cache_pkg::rw_e   proc_rw;
	cache_pkg::addr_t proc_addr;
	cache_pkg::data_t proc_wdata;
	logic             proc_ready;
	cache_pkg::data_t proc_rdata;
	logic             sys_strobe;
	cache_pkg::rw_e   sys_rw;
	cache_pkg::addr_t sys_addr;
	cache_pkg::data_t sys_wdata;
	cache_pkg::data_t sys_rdata;

	integer           seed;
	int               errors       = 0;
	int               checks       = 0;
	int               cycle_count  = 0;
	int               strobe_count = 0;
	int               rd_count     = 0;
	cache_pkg::data_t mem     [65536]; // System memory model
	cache_pkg::data_t ref_mem [65536]; // Expected memory contents
	cache_pkg::addr_t rd_addr;
	cache_pkg::addr_t last_sys_addr;
	cache_pkg::data_t last_sys_wdata;
	cache_pkg::rw_e   last_sys_rw;
	logic [tag_w-1:0] shadow_tag [lines];
	logic [lines-1:0] shadow_valid;

	cache_top #(
		.index_bits  (index_bits),
		.wait_states (wait_states)
	) DUT (
		.clock       (clock),
		.rst_n       (rst_n),
		.proc_strobe (proc_strobe),
		.proc_rw     (proc_rw),
		.proc_addr   (proc_addr),
		.proc_wdata  (proc_wdata),
		.proc_ready  (proc_ready),
		.proc_rdata  (proc_rdata),
		.sys_strobe  (sys_strobe),
		.sys_rw      (sys_rw),
		.sys_addr    (sys_addr),
		.sys_wdata   (sys_wdata),
		.sys_rdata   (sys_rdata)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		if (sys_strobe && sys_rw == cache_pkg::rw_write) begin
			mem[sys_addr] = sys_wdata;
		end else if (sys_strobe) begin
			rd_addr   <= sys_addr;
			rd_count  <= mem_lat;
			sys_rdata <= ~mem[sys_addr]; // Wrong word until the latency has passed
		end else if (rd_count == 1) begin
			sys_rdata <= mem[rd_addr];
			rd_count  <= 0;
		end else if (rd_count != 0) begin
			rd_count <= rd_count - 1;
		end
	end

	// Bus monitor
	always @(negedge clock) begin
		if (sys_strobe) begin
			strobe_count   = strobe_count + 1;
			last_sys_addr  = sys_addr;
			last_sys_wdata = sys_wdata;
			last_sys_rw    = sys_rw;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("sim failed");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	// Returns the cycle of proc_ready, strobe cycle is 0, or -1 if it never came
	task automatic wait_for_ready(output int cyc);
		cyc = 1;
		forever begin
			@(negedge clock);
			if (proc_ready) begin
				return;
			end
			if (cyc >= wait_states + 4) begin
				$display("No proc_ready within %0d cycles of the strobe", cyc);
				errors++;
				cyc = -1;
				return;
			end
			@(posedge clock);
			cyc++;
		end
	endtask

	task automatic run_request(input cache_pkg::rw_e rw, input cache_pkg::addr_t addr,
			input cache_pkg::data_t wdata, input logic exp_hit);
		int cyc;
		int strobes_before;
		int exp_cyc;
		logic [index_bits-1:0] idx;
		begin
			strobes_before = strobe_count;
			idx = addr[index_bits-1:0];
			@(posedge clock);
			proc_strobe <= 1'b1;
			proc_rw     <= rw;
			proc_addr   <= addr;
			proc_wdata  <= wdata;
			@(posedge clock);
			proc_strobe <= 1'b0;
			proc_rw     <= cache_pkg::rw_read;
			proc_addr   <= ~addr; // Request values only valid in the strobe cycle
			proc_wdata  <= ~wdata;
			wait_for_ready(cyc);
			if (cyc < 0) begin
				return;
			end
			if (rw == cache_pkg::rw_read) begin
				exp_cyc = exp_hit ? 1 : wait_states + 3;
				compare("proc_rdata", proc_rdata, ref_mem[addr]);
				compare("sys_strobe count", 16'(strobe_count - strobes_before), exp_hit ? 0 : 1);
			end else begin
				exp_cyc = wait_states + 3;
				ref_mem[addr] = wdata;
				compare("sys_strobe count", 16'(strobe_count - strobes_before), 1);
				compare("sys_addr", last_sys_addr, addr);
				compare("sys_wdata", last_sys_wdata, wdata);
				compare("sys_rw", 16'(last_sys_rw), 16'(cache_pkg::rw_write));
				compare("memory word", mem[addr], wdata);
			end
			compare("proc_ready cycle", 16'(cyc), 16'(exp_cyc));
			shadow_valid[idx] = 1'b1; // Every request leaves the line filled
			shadow_tag[idx]   = addr[cache_pkg::addr_w-1:index_bits];
		end
	endtask

	task automatic apply_reset;
		int i;
		begin
			@(posedge clock);
			rst_n       <= 1'b0;
			proc_strobe <= 1'b0;
			for (i = 1; i < 8; i++) begin
				@(posedge clock);
				@(negedge clock);
				compare("proc_ready", 16'(proc_ready), 16'h0);
				compare("sys_strobe", 16'(sys_strobe), 16'h0);
			end
			@(posedge clock);
			rst_n <= 1'b1;
			shadow_valid = '0;
		end
	endtask

	task automatic read_miss_then_hit;
		run_request(cache_pkg::rw_read, 16'h1234, 16'h0, 1'b0);
		run_request(cache_pkg::rw_read, 16'h1234, 16'h0, 1'b1);
	endtask

	task automatic write_through;
		run_request(cache_pkg::rw_write, 16'h2345, 16'hbeef, 1'b0);
		run_request(cache_pkg::rw_read, 16'h2345, 16'h0, 1'b1);
	endtask

	// Same index 8, different tags
	task automatic conflict_eviction;
		run_request(cache_pkg::rw_read, 16'h4568, 16'h0, 1'b0);
		run_request(cache_pkg::rw_read, 16'h9ab8, 16'h0, 1'b0);
		run_request(cache_pkg::rw_read, 16'h4568, 16'h0, 1'b0);
	endtask

	task automatic reset_invalidation;
		run_request(cache_pkg::rw_read, 16'h1234, 16'h0, 1'b1); // Still cached
		// Reset lands in the cycle that starts the system read of a miss
		@(posedge clock);
		proc_strobe <= 1'b1;
		proc_rw     <= cache_pkg::rw_read;
		proc_addr   <= 16'h7770;
		@(posedge clock);
		proc_strobe <= 1'b0;
		apply_reset();
		run_request(cache_pkg::rw_read, 16'h1234, 16'h0, 1'b0);
	endtask

	task automatic random_mix;
		int n;
		logic [31:0] r;
		cache_pkg::addr_t addr;
		cache_pkg::rw_e rw;
		logic [index_bits-1:0] idx;
		logic predicted;
		begin
			for (n = 0; n < 40; n++) begin
				r = $random(seed);
				addr = {11'h028, r[4:0]}; // 32 words, two tags per line
				rw = r[8] ? cache_pkg::rw_write : cache_pkg::rw_read;
				idx = addr[index_bits-1:0];
				predicted = shadow_valid[idx] &&
					(shadow_tag[idx] == addr[cache_pkg::addr_w-1:index_bits]);
				run_request(rw, addr, r[31:16], predicted);
			end
		end
	endtask

	initial begin
		int i;
		seed = 32'h30223ba9;
		rst_n       <= 1'b0;
		proc_strobe <= 1'b0;
		proc_rw     <= cache_pkg::rw_read;
		proc_addr   <= '0;
		proc_wdata  <= '0;
		sys_rdata   <= '0;
		for (i = 0; i < 65536; i++) begin
			mem[i]     = 16'($random(seed));
			ref_mem[i] = mem[i];
		end
		apply_reset();
		read_miss_then_hit();
		write_through();
		conflict_eviction();
		reset_invalidation();
		random_mix();
		repeat (2) @(posedge clock);
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			DUT.u_cache_ctrl.u_chk.fail_count);
		if (errors == 0 && DUT.u_cache_ctrl.u_chk.fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
source/cache_pkg.sv
source/proc_port.sv
source/cache_store.sv
source/cache_ctrl.sv
source/sys_port.sv
source/cache_top.sv
sim/cache_chk.sv
sim/tb_cache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_cache -f src.f -o sim_cache
status=0
./obj_dir/sim_cache +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
	exit 1
fi
exit 0
